// File: simt_exec.f
+incdir+dv
common/simt_pkg.sv
alu/simt_alu_lane.sv
alu/simt_alu_unit.sv
design/credit_tx_queue.sv
design/exec_cfg_regs.sv
design/simt_exec_top.sv
dv/simt_exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module simt_exec_tb \
    -f simt_exec.f \
    -o simt_exec_sim

./obj_dir/simt_exec_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// File: dv/simt_exec_ref.svh
`ifndef SIMT_EXEC_REF_SVH
`define SIMT_EXEC_REF_SVH

// op1 feeds only the adder and may be the PC, all other ops work on rs1
function automatic logic [31:0] lane_value(input alu_op_e op, input logic [31:0] op1,
                                           input logic [31:0] rs1, input logic [31:0] op2);
    case (op)
        ALU_ADD:  return op1 + op2;
        ALU_SUB:  return rs1 - op2;
        ALU_SLT:  return {31'b0, $signed(rs1) < $signed(op2)};
        ALU_SLTU: return {31'b0, rs1 < op2};
        ALU_SLL:  return rs1 << op2[4:0];
        ALU_SRL:  return rs1 >> op2[4:0];
        ALU_SRA:  return $unsigned($signed(rs1) >>> op2[4:0]);
        ALU_AND:  return rs1 & op2;
        ALU_OR:   return rs1 | op2;
        ALU_XOR:  return rs1 ^ op2;
        default:  return 32'd0;
    endcase
endfunction

function automatic commit_t commit_model(input alu_req_t r, input logic [NUM_LANES-1:0] en);
    commit_t     c;
    logic [31:0] op1;
    logic [31:0] op2;
    c.wid         = r.wid;
    c.thread_mask = r.thread_mask & en;
    c.curr_pc     = r.curr_pc;
    c.rd          = r.rd;
    c.wb          = r.wb;
    for (int i = 0; i < NUM_LANES; i++) begin
        op1 = r.rs1_is_pc ? r.curr_pc : r.rs1_data[i];
        op2 = r.rs2_is_imm ? r.imm : r.rs2_data[i];
        if (r.is_br_op && (r.br_op == BR_JAL || r.br_op == BR_JALR)) begin
            c.data[i] = r.next_pc;
        end else if (r.is_br_op) begin
            // Conditional branches do not write back
            c.data[i] = 32'd0;
        end else begin
            c.data[i] = lane_value(r.alu_op, op1, r.rs1_data[i], op2);
        end
    end
    return c;
endfunction

function automatic branch_t branch_model(input alu_req_t r);
    branch_t     b;
    logic [31:0] a;
    logic [31:0] c;
    a      = r.rs1_data[r.tid];
    c      = r.rs2_data[r.tid];
    b.wid  = r.wid;
    b.dest = (r.rs1_is_pc ? r.curr_pc : a) + (r.rs2_is_imm ? r.imm : c);
    case (r.br_op)
        BR_EQ:   b.taken = (a == c);
        BR_NE:   b.taken = (a != c);
        BR_LT:   b.taken = ($signed(a) < $signed(c));
        BR_GE:   b.taken = ($signed(a) >= $signed(c));
        BR_LTU:  b.taken = (a < c);
        BR_GEU:  b.taken = (a >= c);
        default: b.taken = 1'b1;
    endcase
    return b;
endfunction

`endif

// File: dv/simt_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module simt_exec_tb
    import simt_pkg::*;
;
    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int TIMEOUT     = 500;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 req_valid;
    alu_req_t             req;
    logic                 req_credit;
    logic                 commit_valid;
    commit_t              commit_data;
    logic                 commit_credit = 1'b0;
    logic                 branch_valid;
    branch_t              branch_data;
    logic                 branch_credit = 1'b0;
    logic                 cfg_we;
    logic [1:0]           cfg_addr;
    logic [31:0]          cfg_wdata;
    logic [31:0]          cfg_rdata;

    commit_t              commit_exp[$];
    branch_t              branch_exp[$];
    integer               seed;
    logic [NUM_LANES-1:0] lane_mask;
    logic                 hold_credits;
    int                   issued;
    int                   credits_back;
    int                   commits_seen;
    int                   branches_seen;
    int                   commits_returned;
    int                   branches_returned;
    int                   taken_tally;
    int                   not_taken_tally;
    int                   check_errors;
    int                   flow_errors;
    alu_op_e              alu_ops[10] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLL,
                                          ALU_SRL, ALU_SRA, ALU_AND, ALU_OR, ALU_XOR};

    `include "simt_exec_ref.svh"

    simt_exec_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req),
        .req_credit    (req_credit),
        .commit_valid  (commit_valid),
        .commit_data   (commit_data),
        .commit_credit (commit_credit),
        .branch_valid  (branch_valid),
        .branch_data   (branch_data),
        .branch_credit (branch_credit),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata)
    );

    always #5 clk = ~clk;

    function automatic int show_fail(input string name, input logic [191:0] got,
                                     input logic [191:0] exp);
        $display("[FAIL] %s got %0h expected %0h", name, got, exp);
        return 1;
    endfunction

    always @(posedge clk) begin
        if (req_credit === 1'b1) begin
            credits_back++;
        end
    end

    // Scoreboard compare on outputs sampled just before the edge
    always @(posedge clk) begin
        commit_t got;
        if (commit_valid === 1'b1) begin
            commits_seen++;
            if (commit_exp.size() == 0) begin
                check_errors++;
                $display("A commit arrived that was never issued");
            end else begin
                got = commit_data;
                if (!commit_exp[0].wb) begin
                    got.data = commit_exp[0].data;
                end
                if (got !== commit_exp[0]) begin
                    check_errors += show_fail("commit_data", 192'(got), 192'(commit_exp[0]));
                end
                void'(commit_exp.pop_front());
            end
        end
        if (branch_valid === 1'b1) begin
            branches_seen++;
            if (branch_exp.size() == 0) begin
                check_errors++;
                $display("A branch outcome arrived that was never issued");
            end else begin
                if (branch_data !== branch_exp[0]) begin
                    check_errors += show_fail("branch_data", 192'(branch_data),
                                              192'(branch_exp[0]));
                end
                void'(branch_exp.pop_front());
            end
        end
    end

    // One credit back per output received, unless held back
    always @(negedge clk) begin
        commit_credit = 1'b0;
        branch_credit = 1'b0;
        if (!hold_credits && commits_returned < commits_seen) begin
            commit_credit = 1'b1;
            commits_returned++;
        end
        if (!hold_credits && branches_returned < branches_seen) begin
            branch_credit = 1'b1;
            branches_returned++;
        end
    end

    function automatic alu_req_t random_req(input int kind);
        alu_req_t r;
        int       idx;
        r             = '0;
        r.wid         = WID_BITS'($random(seed));
        r.thread_mask = NUM_LANES'($random(seed));
        r.curr_pc     = $random(seed) & 32'hffff_fffc;
        r.next_pc     = r.curr_pc + 32'd4;
        r.imm         = $random(seed);
        r.rd          = 5'($random(seed));
        r.wb          = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            r.rs1_data[i] = $random(seed);
            r.rs2_data[i] = $random(seed);
        end
        case (kind)
            0: begin
                idx          = ($random(seed) & 32'h7fff_ffff) % 10;
                r.alu_op     = alu_ops[idx];
                r.rs1_is_pc  = 1'($random(seed));
                r.rs2_is_imm = 1'($random(seed));
            end
            1: begin
                r.alu_op = 1'($random(seed)) ? ALU_SLT : ALU_SLTU;
                // Opposite signs in every lane
                for (int i = 0; i < NUM_LANES; i++) begin
                    r.rs2_data[i][31] = ~r.rs1_data[i][31];
                end
            end
            default: begin
                r.is_br_op   = 1'b1;
                r.br_op      = br_op_e'(3'($random(seed)));
                r.tid        = LANE_BITS'($random(seed));
                r.rs2_is_imm = 1'b1;
                r.rs1_is_pc  = (r.br_op != BR_JALR);
                r.wb         = (r.br_op == BR_JAL || r.br_op == BR_JALR);
                if (1'($random(seed))) begin
                    r.rs2_data[r.tid] = r.rs1_data[r.tid];
                end
            end
        endcase
        return r;
    endfunction

    function automatic bit drained();
        return commit_exp.size() == 0 && branch_exp.size() == 0
            && commits_returned == commits_seen && branches_returned == branches_seen
            && issued == credits_back;
    endfunction

    task automatic send_req(input alu_req_t r);
        branch_t b;
        req       = r;
        req_valid = 1'b1;
        issued++;
        commit_exp.push_back(commit_model(r, lane_mask));
        if (r.is_br_op) begin
            b = branch_model(r);
            branch_exp.push_back(b);
            if (b.taken) begin
                taken_tally++;
            end else begin
                not_taken_tally++;
            end
        end
    endtask

    task automatic issue(input alu_req_t r);
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while (issued - credits_back >= QUEUE_DEPTH && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (issued - credits_back >= QUEUE_DEPTH) begin
            flow_errors++;
            $display("Timeout waiting for an issue credit to come back");
        end else begin
            send_req(r);
        end
    endtask

    // A negative kind picks a random mix
    task automatic run_batch(input int kind, input int count);
        int k;
        for (int n = 0; n < count; n++) begin
            k = (kind < 0) ? int'(($random(seed) & 32'h7fff_ffff) % 3) : kind;
            issue(random_req(k));
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while (!drained() && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!drained()) begin
            flow_errors++;
            $display("Timeout with results outstanding: %0d commits, %0d branches",
                     commit_exp.size(), branch_exp.size());
        end
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic cfg_check(input logic [1:0] addr, input logic [31:0] exp, input string name);
        @(negedge clk);
        cfg_addr = addr;
        @(posedge clk);
        if (cfg_rdata !== exp) begin
            flow_errors++;
            $display("[FAIL] cfg_rdata (%s) got %h expected %h", name, cfg_rdata, exp);
        end
    endtask

    // Withheld output credits must stall the queues and then the issuer
    task automatic back_pressure();
        int seen_c;
        int seen_b;
        int sent;
        seen_c       = commits_seen;
        seen_b       = branches_seen;
        sent         = 0;
        hold_credits = 1'b1;
        repeat (40) begin
            @(negedge clk);
            req_valid = 1'b0;
            if (issued - credits_back < QUEUE_DEPTH) begin
                send_req(random_req(int'(($random(seed) & 32'h7fff_ffff) % 3)));
                sent++;
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
        if (commits_seen - seen_c > OUT_CREDITS) begin
            flow_errors++;
            $display("%0d commits left without credits", commits_seen - seen_c);
        end
        if (branches_seen - seen_b > OUT_CREDITS) begin
            flow_errors++;
            $display("%0d branch outcomes left without credits", branches_seen - seen_b);
        end
        if (sent != QUEUE_DEPTH + (commits_seen - seen_c)) begin
            flow_errors++;
            $display("Issuer sent %0d requests under back-pressure, expected %0d",
                     sent, QUEUE_DEPTH + (commits_seen - seen_c));
        end
        hold_credits = 1'b0;
    endtask

    initial begin
        seed         = 32'h1db87625;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        lane_mask    = '1;
        hold_credits = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        run_batch(0, 80);
        run_batch(1, 40);
        run_batch(2, 80);
        wait_drained();

        cfg_write(CFG_LANE_EN, 32'h5);
        lane_mask = NUM_LANES'(5);
        cfg_check(CFG_LANE_EN, 32'h5, "lane_en");
        run_batch(-1, 40);
        wait_drained();
        cfg_write(CFG_LANE_EN, 32'hf);
        lane_mask = '1;

        back_pressure();
        wait_drained();

        cfg_check(CFG_TAKEN_CNT, taken_tally, "taken count");
        cfg_check(CFG_NOT_TAKEN_CNT, not_taken_tally, "not-taken count");
        // Nonzero data, the counter must still clear
        cfg_write(CFG_TAKEN_CNT, 32'hffff_ffff);
        cfg_write(CFG_NOT_TAKEN_CNT, 32'hffff_ffff);
        cfg_check(CFG_TAKEN_CNT, 32'd0, "taken count after clear");
        cfg_check(CFG_NOT_TAKEN_CNT, 32'd0, "not-taken count after clear");

        $display("Scoreboard errors %0d, flow errors %0d, commits %0d, branches %0d",
                 check_errors, flow_errors, commits_seen, branches_seen);
        if (check_errors + flow_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/simt_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module simt_exec_top
    import simt_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req_valid,
    input  alu_req_t    req,
    output logic        req_credit,
    output logic        commit_valid,
    output commit_t     commit_data,
    input  logic        commit_credit,
    output logic        branch_valid,
    output branch_t     branch_data,
    input  logic        branch_credit,
    input  logic        cfg_we,
    input  logic [1:0]  cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata
);
    logic [NUM_LANES-1:0] lane_en;
    logic                 br_event;
    logic                 br_taken;
    logic                 stage_valid;
    commit_t              stage_commit;
    logic                 stage_br_valid;
    branch_t              stage_branch;
    logic                 commit_popped;

    exec_cfg_regs cfg_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .br_event  (br_event),
        .br_taken  (br_taken),
        .lane_en   (lane_en)
    );

    simt_alu_unit alu_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req          (req),
        .lane_en      (lane_en),
        .stage_valid  (stage_valid),
        .commit_data  (stage_commit),
        .branch_valid (stage_br_valid),
        .branch_data  (stage_branch),
        .br_event     (br_event),
        .br_taken     (br_taken)
    );

    credit_tx_queue #(
        .payload_t (commit_t),
        .DEPTH     (QUEUE_DEPTH),
        .CREDITS   (OUT_CREDITS)
    ) commit_q_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (stage_valid),
        .in_data   (stage_commit),
        .out_valid (commit_valid),
        .out_data  (commit_data),
        .credit_in (commit_credit),
        .popped    (commit_popped)
    );

    // Sized like the commit queue, so every branch always has a slot
    credit_tx_queue #(
        .payload_t (branch_t),
        .DEPTH     (QUEUE_DEPTH),
        .CREDITS   (OUT_CREDITS)
    ) branch_q_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (stage_br_valid),
        .in_data   (stage_branch),
        .out_valid (branch_valid),
        .out_data  (branch_data),
        .credit_in (branch_credit),
        .popped    ()
    );

    // Each commit that leaves frees one issuer slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_credit <= 1'b0;
        end else begin
            req_credit <= commit_popped;
        end
    end

endmodule

`default_nettype wire

// File: design/exec_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cfg_regs
    import simt_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cfg_we,
    input  logic [1:0]           cfg_addr,
    input  logic [31:0]          cfg_wdata,
    output logic [31:0]          cfg_rdata,
    input  logic                 br_event,
    input  logic                 br_taken,
    output logic [NUM_LANES-1:0] lane_en
);
    logic [31:0] taken_cnt;
    logic [31:0] not_taken_cnt;
    logic        wr_lane_en;
    logic        wr_taken;
    logic        wr_not_taken;

    assign wr_lane_en   = cfg_we && (cfg_addr == CFG_LANE_EN);
    assign wr_taken     = cfg_we && (cfg_addr == CFG_TAKEN_CNT);
    assign wr_not_taken = cfg_we && (cfg_addr == CFG_NOT_TAKEN_CNT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_en <= '1;
        end else if (wr_lane_en) begin
            lane_en <= cfg_wdata[NUM_LANES-1:0];
        end
    end

    // A write clears the counter whatever the data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            taken_cnt <= '0;
        end else if (wr_taken) begin
            taken_cnt <= '0;
        end else if (br_event && br_taken) begin
            taken_cnt <= taken_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            not_taken_cnt <= '0;
        end else if (wr_not_taken) begin
            not_taken_cnt <= '0;
        end else if (br_event && !br_taken) begin
            not_taken_cnt <= not_taken_cnt + 32'd1;
        end
    end

    always_comb begin
        case (cfg_addr)
            CFG_LANE_EN:       cfg_rdata = {{(32 - NUM_LANES){1'b0}}, lane_en};
            CFG_TAKEN_CNT:     cfg_rdata = taken_cnt;
            CFG_NOT_TAKEN_CNT: cfg_rdata = not_taken_cnt;
            default:           cfg_rdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/credit_tx_queue.sv
`timescale 1ns/1ps
`default_nettype none

module credit_tx_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4,
    parameter int  CREDITS   = 2
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     credit_in,
    output logic     popped
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(CREDITS + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] tx_credits;
    logic             send;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    // Head leaves whenever the consumer has granted a credit
    assign send      = (count != '0) && (tx_credits != '0);
    assign out_valid = send;
    assign out_data  = mem[rd_ptr];
    assign popped    = send;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (send) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({in_valid, send})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_credits <= CRD_W'(CREDITS);
        end else begin
            case ({credit_in, send})
                2'b10:   tx_credits <= tx_credits + CRD_W'(1);
                2'b01:   tx_credits <= tx_credits - CRD_W'(1);
                default: tx_credits <= tx_credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: alu/simt_alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module simt_alu_unit
    import simt_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  alu_req_t             req,
    input  logic [NUM_LANES-1:0] lane_en,
    output logic                 stage_valid,
    output commit_t              commit_data,
    output logic                 branch_valid,
    output branch_t              branch_data,
    output logic                 br_event,
    output logic                 br_taken
);
    logic [NUM_LANES-1:0][31:0] lane_add;
    logic [NUM_LANES-1:0][32:0] lane_sub;
    logic [NUM_LANES-1:0][31:0] lane_res;
    alu_op_e                    lane_op;
    logic                       br_signed;
    logic                       is_jal;
    commit_t                    commit_d;

    logic                       valid_r;
    commit_t                    commit_r;
    logic                       is_br_r;
    br_op_e                     br_op_r;
    logic [31:0]                dest_r;
    logic [32:0]                cmp_r;

    logic                       is_less;
    logic                       is_equal;
    logic                       br_neg;
    logic                       br_less;
    logic                       br_static;

    // Branches run the lanes as slt or sltu so the subtract extends correctly
    assign br_signed = req.br_op[2] & req.br_op[0];
    assign lane_op   = req.is_br_op ? (br_signed ? ALU_SLT : ALU_SLTU) : req.alu_op;
    assign is_jal    = req.is_br_op && (req.br_op == BR_JAL || req.br_op == BR_JALR);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [31:0] pc_in1;
        logic [31:0] in2_imm;
        logic [31:0] in2_cmp;

        assign pc_in1  = req.rs1_is_pc ? req.curr_pc : req.rs1_data[i];
        assign in2_imm = req.rs2_is_imm ? req.imm : req.rs2_data[i];
        // Branch compare always uses rs2, the immediate only feeds the target
        assign in2_cmp = (req.rs2_is_imm && !req.is_br_op) ? req.imm : req.rs2_data[i];

        simt_alu_lane lane_i (
            .in1     (req.rs1_data[i]),
            .in2_imm (in2_imm),
            .in2_cmp (in2_cmp),
            .pc_in1  (pc_in1),
            .alu_op  (lane_op),
            .add_out (lane_add[i]),
            .sub_out (lane_sub[i]),
            .result  (lane_res[i])
        );
    end

    always_comb begin
        commit_d.wid         = req.wid;
        commit_d.thread_mask = req.thread_mask & lane_en;
        commit_d.curr_pc     = req.curr_pc;
        commit_d.rd          = req.rd;
        commit_d.wb          = req.wb;
        for (int i = 0; i < NUM_LANES; i++) begin
            // Link value for jal and jalr
            commit_d.data[i] = is_jal ? req.next_pc : lane_res[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            commit_r <= commit_d;
            is_br_r  <= req.is_br_op;
            br_op_r  <= req.br_op;
            dest_r   <= lane_add[req.tid];
            cmp_r    <= lane_sub[req.tid];
        end
    end

    assign is_less   = cmp_r[32];
    assign is_equal  = ~|cmp_r[31:0];
    assign br_neg    = br_op_r[1];
    assign br_less   = br_op_r[2];
    assign br_static = ~br_op_r[2] & br_op_r[0];
    assign br_taken  = ((br_less ? is_less : is_equal) ^ br_neg) | br_static;

    assign stage_valid  = valid_r;
    assign commit_data  = commit_r;
    assign branch_valid = valid_r & is_br_r;
    assign br_event     = valid_r & is_br_r;

    always_comb begin
        branch_data.wid   = commit_r.wid;
        branch_data.taken = br_taken;
        branch_data.dest  = dest_r;
    end

endmodule

`default_nettype wire

// File: alu/simt_alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module simt_alu_lane
    import simt_pkg::*;
(
    input  logic [31:0] in1,
    input  logic [31:0] in2_imm,
    input  logic [31:0] in2_cmp,
    input  logic [31:0] pc_in1,
    input  alu_op_e     alu_op,
    output logic [31:0] add_out,
    output logic [32:0] sub_out,
    output logic [31:0] result
);
    logic        op_signed;
    logic [1:0]  op_class;
    logic [32:0] sub_in1;
    logic [32:0] sub_in2;
    logic [32:0] shr_in;
    logic [31:0] shr_out;
    logic [31:0] msc_out;

    assign op_signed = alu_op[0];
    assign op_class  = alu_op[3:2];

    // Also the branch target adder
    assign add_out = pc_in1 + in2_imm;

    // One 33-bit subtract covers signed and unsigned compares
    assign sub_in1 = {op_signed & in1[31], in1};
    assign sub_in2 = {op_signed & in2_cmp[31], in2_cmp};
    assign sub_out = sub_in1 - sub_in2;

    // Extension bit supplies the fill for sra, zero for srl
    assign shr_in  = {op_signed & in1[31], in1};
    assign shr_out = 32'($signed(shr_in) >>> in2_imm[4:0]);

    always_comb begin
        case (alu_op)
            ALU_AND: msc_out = in1 & in2_imm;
            ALU_OR:  msc_out = in1 | in2_imm;
            ALU_XOR: msc_out = in1 ^ in2_imm;
            default: msc_out = in1 << in2_imm[4:0];
        endcase
    end

    always_comb begin
        case (op_class)
            2'd0: begin
                result = add_out;
            end
            2'd1: begin
                result = {31'b0, sub_out[32]};
            end
            2'd2: begin
                result = (alu_op == ALU_SUB) ? sub_out[31:0] : shr_out;
            end
            default: begin
                result = msc_out;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: common/simt_pkg.sv
`default_nettype none

package simt_pkg;

    localparam int NUM_LANES = 4;
    localparam int WID_BITS  = 2;
    localparam int LANE_BITS = $clog2(NUM_LANES);

    // Bits 3:2 pick the result class, bit 0 marks a signed operation
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLTU = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SRL  = 4'b1000,
        ALU_SRA  = 4'b1001,
        ALU_SUB  = 4'b1011,
        ALU_AND  = 4'b1100,
        ALU_OR   = 4'b1101,
        ALU_XOR  = 4'b1110,
        ALU_SLL  = 4'b1111
    } alu_op_e;

    // Bit 2 selects less over equal, bit 1 negates
    // Bit 0 means signed compare when bit 2 is set, unconditional jump otherwise
    typedef enum logic [2:0] {
        BR_EQ   = 3'b000,
        BR_JAL  = 3'b001,
        BR_NE   = 3'b010,
        BR_JALR = 3'b011,
        BR_LTU  = 3'b100,
        BR_LT   = 3'b101,
        BR_GEU  = 3'b110,
        BR_GE   = 3'b111
    } br_op_e;

    typedef struct packed {
        logic [WID_BITS-1:0]        wid;
        logic [NUM_LANES-1:0]       thread_mask;
        logic [31:0]                curr_pc;
        logic [31:0]                next_pc;
        logic [31:0]                imm;
        logic [NUM_LANES-1:0][31:0] rs1_data;
        logic [NUM_LANES-1:0][31:0] rs2_data;
        logic                       rs1_is_pc;
        logic                       rs2_is_imm;
        logic                       is_br_op;
        alu_op_e                    alu_op;
        br_op_e                     br_op;
        logic [LANE_BITS-1:0]       tid;
        logic [4:0]                 rd;
        logic                       wb;
    } alu_req_t;

    typedef struct packed {
        logic [WID_BITS-1:0]        wid;
        logic [NUM_LANES-1:0]       thread_mask;
        logic [31:0]                curr_pc;
        logic [4:0]                 rd;
        logic                       wb;
        logic [NUM_LANES-1:0][31:0] data;
    } commit_t;

    typedef struct packed {
        logic [WID_BITS-1:0] wid;
        logic                taken;
        logic [31:0]         dest;
    } branch_t;

    localparam logic [1:0] CFG_LANE_EN       = 2'd0;
    localparam logic [1:0] CFG_TAKEN_CNT     = 2'd1;
    localparam logic [1:0] CFG_NOT_TAKEN_CNT = 2'd2;

endpackage

`default_nettype wire
